// File: sources.f
+incdir+design
design/jio_bus_pkg.sv
design/jio_periph_pkg.sv
design/jio_decode.sv
design/jio_wb_slave.sv
design/jio_timer.sv
design/jio_irq_ctrl.sv
design/jio_top.sv
tests/jio_chk.sv
tests/jio_tb.sv

// File: tests/jio_tb.sv
/* Drives jio_top as a Wishbone master from the falling edge. Timer periods are
   kept small (6 to 30 cycles) so that pending bits can be cleared between ticks. */
`timescale 1ns/100ps
`include "jio_settings.svh"

module jio_tb;

	localparam int N_RAND      = 64;
	localparam int WIN_PERIODS = 10;
	localparam int MAX_PERIOD  = 30;
	// Rough length of all tests in clock cycles
	localparam int PLAN_CYCLES = 60 + N_RAND * 3 + 2 * (WIN_PERIODS * MAX_PERIOD + 60)
		+ 2 * MAX_PERIOD + 200;

	logic                   sys_clk = 1'b0;
	logic                   rst_n;
	jio_bus_pkg::jio_req_t  req;
	logic                   ack;
	jio_bus_pkg::jio_data_t dat_o;
	logic                   irq;
	logic [5:0]             gpio_cs_n;

	integer   seed = 32'h4957;
	int       errors = 0;
	// Model of the interrupt register
	logic [1:0] en_m;
	logic [1:0] pend_m;

	jio_top jio_top_inst (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.req       (req),
		.ack       (ack),
		.dat_o     (dat_o),
		.irq       (irq),
		.gpio_cs_n (gpio_cs_n)
	);

	always #2 sys_clk = ~sys_clk;

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Mismatch at %0t: %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	// Expected selects, from the six address ranges of the window
	function automatic logic [5:0] gpio_exp(input logic [15:0] a);
		logic [5:0] cs_n;
		cs_n = 6'h3F;
		if (a >= `JIO_GPIO_LO && a <= 16'h4FFF)
			cs_n[0] = 1'b0;
		else if (a >= 16'h5000 && a <= 16'h5FFF)
			cs_n[1] = 1'b0;
		else if (a >= 16'h6000 && a <= 16'h6FFF)
			cs_n[2] = 1'b0;
		else if (a >= 16'h7000 && a <= 16'h77FF)
			cs_n[3] = 1'b0;
		else if (a >= 16'h7800 && a <= 16'h7BFF)
			cs_n[4] = 1'b0;
		else if (a >= 16'h7C00 && a <= `JIO_GPIO_HI)
			cs_n[5] = 1'b0;
		return cs_n;
	endfunction

	// Addresses that have a readable register, byte bit ignored
	function automatic logic is_reg_read(input logic [15:0] a);
		logic [15:0] w;
		w = a & 16'hFFFE;
		return w == `JIO_INT_ADR || (w >= `JIO_PIT1R_ADR && w <= `JIO_PIT4R_ADR);
	endfunction

	// One transfer, called and left on a falling edge
	task automatic bus_xfer(input logic we, input logic [15:0] adr, input logic [15:0] wdat,
			output logic [15:0] rdat);
		int waited;
		waited = 0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = wdat;
		do begin
			@(negedge sys_clk);
			waited++;
		end while (!ack && waited < 8);
		assert (ack) else begin
			errors++;
			$display("No ack from the DUT within 8 cycles at %0t, address %h", $time, adr);
		end
		check_val("ack delay", 16'(waited), 16'd1);
		check_val("gpio_cs_n", gpio_cs_n, gpio_exp(adr));
		rdat = dat_o;
		// Master takes ack on the next rising edge, the write lands there
		@(negedge sys_clk);
		check_val("ack", ack, 1'b0);
		req = '0;
	endtask

	task automatic bus_write(input logic [15:0] adr, input logic [15:0] wdat);
		logic [15:0] unused;
		bus_xfer(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input logic [15:0] adr, output logic [15:0] rdat);
		bus_xfer(1'b0, adr, 16'h0000, rdat);
	endtask

	task automatic check_int_reg();
		logic [15:0] rd;
		bus_read(`JIO_INT_ADR, rd);
		check_val("int register", rd, {6'b0, pend_m, 6'b0, en_m});
	endtask

	initial begin
		#(PLAN_CYCLES * 20 * 4);
		$display("Timeout: run did not finish in time, %0d errors so far", errors);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [15:0] rd;
		logic [15:0] adr;
		int          pre;
		int          div;
		int          period;
		int          hits;
		time         t_end;
		req    = '0;
		rst_n  = 1'b0;
		en_m   = 2'b00;
		pend_m = 2'b00;
		repeat (4) @(negedge sys_clk);
		rst_n = 1'b1;

		// Reset values
		check_val("ack", ack, 1'b0);
		check_val("irq", irq, 1'b0);
		check_val("gpio_cs_n", gpio_cs_n, 6'h3F);
		check_val("tmr1 tick", jio_top_inst.tmr1_stat.tick, 1'b0);
		check_val("tmr2 tick", jio_top_inst.tmr2_stat.tick, 1'b0);
		check_int_reg();
		for (int i = 0; i < 4; i++) begin
			bus_read(`JIO_PIT1R_ADR + 16'(2 * i), rd);
			check_val("timer count", rd, 16'h0000);
		end

		// Random reads, biased to the GPIO window and the low register block
		for (int i = 0; i < N_RAND; i++) begin
			adr = $random(seed);
			case ({$random(seed)} % 3)
				0: adr = {2'b01, adr[13:0]};
				1: adr = {10'b0, adr[5:0]};
				default: ;
			endcase
			if (!is_reg_read(adr)) begin
				bus_read(adr, rd);
				check_val("dat_o", rd, 16'h0000);
			end
		end

		// Tick rate of each timer, seen as pending with its enable set
		for (int t = 0; t < 2; t++) begin
			pre    = 2 + {$random(seed)} % 4;
			div    = 1 + {$random(seed)} % 4;
			period = (pre + 1) * (div + 1);
			en_m   = 2'(1 << t);
			bus_write(`JIO_INT_ADR, {6'b0, 2'b11, 6'b0, en_m});
			bus_write(t ? `JIO_PIT3_ADR : `JIO_PIT1_ADR, 16'(pre));
			bus_write(t ? `JIO_PIT4_ADR : `JIO_PIT2_ADR, 16'(div));
			hits  = 0;
			t_end = $time + WIN_PERIODS * period * 4;
			while ($time < t_end) begin
				@(negedge sys_clk);
				if (irq) begin
					hits++;
					bus_write(`JIO_INT_ADR, {6'b0, 2'b11, 6'b0, en_m});
				end
			end
			assert (hits >= WIN_PERIODS - 1 && hits <= WIN_PERIODS + 1) else begin
				errors++;
				$display("Mismatch at %0t: tick count got %0d exp %0d", $time, hits,
					WIN_PERIODS);
			end
			// Live counts stay within their reloads
			bus_read(t ? `JIO_PIT3R_ADR : `JIO_PIT1R_ADR, rd);
			assert (rd <= pre) else begin
				errors++;
				$display("Mismatch at %0t: prescaler count got %0d exp <= %0d", $time, rd, pre);
			end
			bus_read(t ? `JIO_PIT4R_ADR : `JIO_PIT2R_ADR, rd);
			assert (rd <= div) else begin
				errors++;
				$display("Mismatch at %0t: divider count got %0d exp <= %0d", $time, rd, div);
			end
		end

		// Masked sources pend without raising irq
		en_m = 2'b00;
		bus_write(`JIO_INT_ADR, 16'h0300);
		repeat (2 * MAX_PERIOD + 4) @(negedge sys_clk);
		check_val("irq", irq, 1'b0);
		// Divider reload of zero stops both timers
		bus_write(`JIO_PIT2_ADR, 16'h0000);
		bus_write(`JIO_PIT4_ADR, 16'h0000);
		pend_m = 2'b11;
		check_int_reg();
		check_val("irq", irq, 1'b0);

		// Enable and clear one source at a time
		en_m = 2'b01;
		bus_write(`JIO_INT_ADR, {14'b0, en_m});
		check_val("irq", irq, 1'b1);
		pend_m = 2'b10;
		bus_write(`JIO_INT_ADR, {6'b0, 2'b01, 6'b0, en_m});
		check_val("irq", irq, 1'b0);
		check_int_reg();
		en_m = 2'b11;
		bus_write(`JIO_INT_ADR, {14'b0, en_m});
		check_val("irq", irq, 1'b1);
		pend_m = 2'b00;
		bus_write(`JIO_INT_ADR, {6'b0, 2'b10, 6'b0, en_m});
		check_val("irq", irq, 1'b0);

		// Stopped timers stay silent
		repeat (2 * MAX_PERIOD + 40) begin
			@(negedge sys_clk);
			check_val("irq", irq, 1'b0);
		end
		check_int_reg();

		// Protocol checker failures count as errors too
		errors += jio_top_inst.wb_slave_inst.chk_inst.fail_cnt;
		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: tests/jio_chk.sv
/* Bound into the Wishbone slave. Checks the handshake and strobes only, not data. */
`timescale 1ns/100ps

module jio_chk (
	input logic                   sys_clk,
	input logic                   rst_n,
	input jio_bus_pkg::jio_req_t  req,
	input logic                   ack,
	input jio_bus_pkg::jio_strb_t strb
);

	// Failed assertions, summed into the testbench error total
	int fail_cnt = 0;

	// Fresh request is acked on the next edge
	ack_follows_stb: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(req.cyc && req.stb && !ack) |=> ack)
		else begin
			fail_cnt++;
			$error("ack did not follow stb within one cycle");
		end

	// Single-cycle ack, low again before the next one
	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (!rst_n)
		ack |=> !ack)
		else begin
			fail_cnt++;
			$error("ack high for two cycles in a row");
		end

	// At most one register strobe
	strb_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$onehot0(strb))
		else begin
			fail_cnt++;
			$error("more than one register strobe active");
		end

endmodule

bind jio_wb_slave jio_chk chk_inst (
	.sys_clk (sys_clk),
	.rst_n   (rst_n),
	.req     (req),
	.ack     (ack),
	.strb    (strb)
);

// File: design/jio_top.sv
/* Local I/O block: Wishbone slave, decoder, two interval timers and the interrupt
   register. Word accesses only, no back-pressure. */
`timescale 1ns/100ps

module jio_top (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  jio_bus_pkg::jio_req_t  req,
	output logic                   ack,
	output jio_bus_pkg::jio_data_t dat_o,
	output logic                   irq,
	output logic [5:0]             gpio_cs_n
);

	// Raw address matches and qualified strobes
	jio_bus_pkg::jio_strb_t        raw;
	jio_bus_pkg::jio_strb_t        strb;
	// Timer status towards the bus and the interrupts
	jio_periph_pkg::jio_tmr_stat_t tmr1_stat;
	jio_periph_pkg::jio_tmr_stat_t tmr2_stat;
	// Interrupt register readback
	jio_bus_pkg::jio_data_t        int_rd;
	logic                          bus_sel;

	// Cycle in progress, gates the external selects
	assign bus_sel = req.cyc & req.stb;

	jio_wb_slave wb_slave_inst (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.req     (req),
		.raw     (raw),
		.tmr1    (tmr1_stat),
		.tmr2    (tmr2_stat),
		.int_rd  (int_rd),
		.strb    (strb),
		.ack     (ack),
		.dat_o   (dat_o)
	);

	jio_decode decode_inst (
		.adr       (req.adr),
		.we        (req.we),
		.sel       (bus_sel),
		.raw       (raw),
		.gpio_cs_n (gpio_cs_n)
	);

	// Timer 1 at pit1/pit2, timer 2 at pit3/pit4
	jio_timer tmr1_inst (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.pre_we  (strb.pit1w),
		.div_we  (strb.pit2w),
		.wdat    (req.dat),
		.stat    (tmr1_stat)
	);

	jio_timer tmr2_inst (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.pre_we  (strb.pit3w),
		.div_we  (strb.pit4w),
		.wdat    (req.dat),
		.stat    (tmr2_stat)
	);

	// Timer 1 drives source 0
	jio_irq_ctrl irq_ctrl_inst (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.we      (strb.int1w),
		.wdat    (req.dat),
		.tick    ({tmr2_stat.tick, tmr1_stat.tick}),
		.rd      (int_rd),
		.irq     (irq)
	);

endmodule

// File: design/jio_irq_ctrl.sv
/* Enables in bits 1:0, pending in bits 9:8. Write 1 to bit 8+i clears pending i,
   and a tick in the same cycle wins. */
`timescale 1ns/100ps

module jio_irq_ctrl (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic                   we,
	input  jio_bus_pkg::jio_data_t wdat,
	input  logic [1:0]             tick,
	output jio_bus_pkg::jio_data_t rd,
	output logic                   irq
);

	jio_periph_pkg::jio_irq_t en;
	jio_periph_pkg::jio_irq_t pend;
	jio_periph_pkg::jio_irq_t clr;

	// Clear mask only during a write
	assign clr = we ? wdat[9:8] : '0;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			en   <= '0;
			pend <= '0;
		end else begin
			if (we)
				en <= wdat[1:0];
			// Set after clear so a fresh tick is never lost
			pend <= (pend & ~clr) | tick;
		end
	end

	// Readback layout matches the write layout
	assign rd  = {6'b0, pend, 6'b0, en};

	// Request while any enabled source is pending
	assign irq = |(pend & en);

endmodule

// File: design/jio_timer.sv
/* Tick period is (pre+1)*(div+1) cycles. A divider reload of zero stops the timer,
   and any reload write restarts both counters. */
`timescale 1ns/100ps
`include "jio_settings.svh"

module jio_timer (
	input  logic                          sys_clk,
	input  logic                          rst_n,
	input  logic                          pre_we,
	input  logic                          div_we,
	input  jio_bus_pkg::jio_data_t        wdat,
	output jio_periph_pkg::jio_tmr_stat_t stat
);

	jio_periph_pkg::jio_tmr_state_t state;
	jio_periph_pkg::jio_cnt_t       pre_rld;
	jio_periph_pkg::jio_cnt_t       div_rld;
	jio_periph_pkg::jio_cnt_t       pre_cnt;
	jio_periph_pkg::jio_cnt_t       div_cnt;
	jio_periph_pkg::jio_cnt_t       wval;
	logic                           pre_zero;
	logic                           div_zero;

	// Bus word trimmed to counter width
	assign wval     = `JIO_TMR_W'(wdat);
	assign pre_zero = pre_cnt == '0;
	assign div_zero = div_cnt == '0;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= jio_periph_pkg::TMR_IDLE;
			pre_rld <= '0;
			div_rld <= '0;
			pre_cnt <= '0;
			div_cnt <= '0;
		end else if (div_we) begin
			// Divider reload decides run or idle
			div_rld <= wval;
			div_cnt <= wval;
			pre_cnt <= pre_rld;
			state   <= (wval != '0) ? jio_periph_pkg::TMR_RUN : jio_periph_pkg::TMR_IDLE;
		end else if (pre_we) begin
			pre_rld <= wval;
			pre_cnt <= wval;
			div_cnt <= div_rld;
		end else if (state == jio_periph_pkg::TMR_RUN) begin
			if (pre_zero) begin
				// Prescaler wraps, divider takes one step
				pre_cnt <= pre_rld;
				div_cnt <= div_zero ? div_rld : div_cnt - 1'b1;
			end else begin
				pre_cnt <= pre_cnt - 1'b1;
			end
		end
	end

	assign stat.pre_cnt = pre_cnt;
	assign stat.div_cnt = div_cnt;
	// Both at zero marks the last cycle of a period
	assign stat.tick    = (state == jio_periph_pkg::TMR_RUN) & pre_zero & div_zero;

endmodule

// File: design/jio_wb_slave.sv
/* Never stalls and never signals err/rty. One transfer at a time, ack one cycle
   after stb, then low for at least one cycle. Unmapped reads return zero. */
`timescale 1ns/100ps

module jio_wb_slave (
	input  logic                          sys_clk,
	input  logic                          rst_n,
	input  jio_bus_pkg::jio_req_t         req,
	input  jio_bus_pkg::jio_strb_t        raw,
	input  jio_periph_pkg::jio_tmr_stat_t tmr1,
	input  jio_periph_pkg::jio_tmr_stat_t tmr2,
	input  jio_bus_pkg::jio_data_t        int_rd,
	output jio_bus_pkg::jio_strb_t        strb,
	output logic                          ack,
	output jio_bus_pkg::jio_data_t        dat_o
);

	// Strobe bits that belong to writes, the rest are reads
	localparam jio_bus_pkg::jio_strb_t WR_BITS = '{
		pit1w: 1'b1,
		pit2w: 1'b1,
		pit3w: 1'b1,
		pit4w: 1'b1,
		int1w: 1'b1,
		default: 1'b0
	};

	logic                   start;
	jio_bus_pkg::jio_data_t rd_mux;

	// New request seen, not already in its ack cycle
	assign start = req.cyc & req.stb & ~ack;

	// Read source select, one raw read strobe at most
	always_comb begin
		rd_mux = '0;
		if (raw.pit1r)
			rd_mux = tmr1.pre_cnt;
		else if (raw.pit2r)
			rd_mux = tmr1.div_cnt;
		else if (raw.pit3r)
			rd_mux = tmr2.pre_cnt;
		else if (raw.pit4r)
			rd_mux = tmr2.div_cnt;
		else if (raw.int1r)
			rd_mux = int_rd;
	end

	// ack and read data leave on the same edge
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			ack   <= 1'b0;
			dat_o <= '0;
		end else begin
			ack <= start;
			if (start)
				dat_o <= rd_mux;
		end
	end

	// Strobes live only in the ack cycle, so a write lands on the edge ending it
	always_comb begin
		strb = '0;
		if (ack && req.cyc && req.stb)
			strb = raw & (req.we ? WR_BITS : ~WR_BITS);
	end

endmodule

// File: design/jio_decode.sv
/* Raw strobes are address and direction matches only, not yet qualified by cyc/stb.
   Dropped registers (serial port, clock dividers, joysticks) decode to nothing. */
`timescale 1ns/100ps
`include "jio_settings.svh"

module jio_decode (
	input  jio_bus_pkg::jio_addr_t adr,
	input  logic                   we,
	input  logic                   sel,
	output jio_bus_pkg::jio_strb_t raw,
	output logic [5:0]             gpio_cs_n
);

	// Offsets held as typed constants so the word part can be sliced
	localparam jio_bus_pkg::jio_addr_t PIT1W = `JIO_PIT1_ADR;
	localparam jio_bus_pkg::jio_addr_t PIT2W = `JIO_PIT2_ADR;
	localparam jio_bus_pkg::jio_addr_t PIT3W = `JIO_PIT3_ADR;
	localparam jio_bus_pkg::jio_addr_t PIT4W = `JIO_PIT4_ADR;
	localparam jio_bus_pkg::jio_addr_t PIT1R = `JIO_PIT1R_ADR;
	localparam jio_bus_pkg::jio_addr_t PIT2R = `JIO_PIT2R_ADR;
	localparam jio_bus_pkg::jio_addr_t PIT3R = `JIO_PIT3R_ADR;
	localparam jio_bus_pkg::jio_addr_t PIT4R = `JIO_PIT4R_ADR;
	localparam jio_bus_pkg::jio_addr_t INTA  = `JIO_INT_ADR;

	logic       in_gpio;
	logic [5:0] gpio_hit;

	// Word match over the full address, byte bit dropped
	function automatic logic reg_hit(
		input jio_bus_pkg::jio_addr_t a,
		input jio_bus_pkg::jio_addr_t off
	);
		return a[`JIO_ADR_W-1:1] == off[`JIO_ADR_W-1:1];
	endfunction

	always_comb begin
		raw = '0;
		// Timer reloads, write only
		raw.pit1w = we & reg_hit(adr, PIT1W);
		raw.pit2w = we & reg_hit(adr, PIT2W);
		raw.pit3w = we & reg_hit(adr, PIT3W);
		raw.pit4w = we & reg_hit(adr, PIT4W);
		// Live counts, read only
		raw.pit1r = ~we & reg_hit(adr, PIT1R);
		raw.pit2r = ~we & reg_hit(adr, PIT2R);
		raw.pit3r = ~we & reg_hit(adr, PIT3R);
		raw.pit4r = ~we & reg_hit(adr, PIT4R);
		// Interrupt register shares one address for both directions
		raw.int1w = we & reg_hit(adr, INTA);
		raw.int1r = ~we & reg_hit(adr, INTA);
	end

	// Overall external window
	assign in_gpio = (adr >= `JIO_GPIO_LO) && (adr <= `JIO_GPIO_HI);

	// 0x4800-0x4FFF, CD interface
	assign gpio_hit[0] = adr[15:11] == 5'b01001;
	// 0x5000-0x5FFF, DMA ack
	assign gpio_hit[1] = adr[15:12] == 4'h5;
	// 0x6000-0x6FFF, cartridge
	assign gpio_hit[2] = adr[15:12] == 4'h6;
	// 0x7000-0x77FF
	assign gpio_hit[3] = adr[15:11] == 5'b01110;
	// 0x7800-0x7BFF
	assign gpio_hit[4] = adr[15:10] == 6'b011110;
	// 0x7C00-0x7FFF, paddle interface
	assign gpio_hit[5] = adr[15:10] == 6'b011111;

	// Active low, only while a cycle is on the bus
	assign gpio_cs_n = ~(gpio_hit & {6{sel & in_gpio}});

endmodule

// File: design/jio_periph_pkg.sv
/* Timer and interrupt types. Two timers, hence two interrupt sources. */
`include "jio_settings.svh"

package jio_periph_pkg;

	// Prescaler or divider value, reload or live count
	typedef logic [`JIO_TMR_W-1:0] jio_cnt_t;

	// One bit per interrupt source, timer 1 in bit 0
	typedef logic [1:0] jio_irq_t;

	// Timer runs only while its divider reload is non-zero
	typedef enum logic {
		TMR_IDLE,
		TMR_RUN
	} jio_tmr_state_t;

	// What a timer shows to the bus and the interrupt logic
	typedef struct packed {
		jio_cnt_t pre_cnt;
		jio_cnt_t div_cnt;
		// High for one cycle at the end of each period
		logic     tick;
	} jio_tmr_stat_t;

endpackage

// File: design/jio_bus_pkg.sv
/* Wishbone side types. Word accesses only, with no sel, err or rty. */
`include "jio_settings.svh"

package jio_bus_pkg;

	// Byte address into local space
	typedef logic [`JIO_ADR_W-1:0] jio_addr_t;

	// One bus data word
	typedef logic [`JIO_DAT_W-1:0] jio_data_t;

	// Request as driven by the master
	// Held stable until ack is seen
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		jio_addr_t adr;
		jio_data_t dat;
	} jio_req_t;

	// One bit per internal register strobe
	// Same struct for raw address matches and for qualified strobes
	typedef struct packed {
		// Timer 1 prescaler / divider reload writes
		logic pit1w;
		logic pit2w;
		// Timer 2 prescaler / divider reload writes
		logic pit3w;
		logic pit4w;
		// Count readbacks, same order as the writes
		logic pit1r;
		logic pit2r;
		logic pit3r;
		logic pit4r;
		// Interrupt register
		logic int1w;
		logic int1r;
	} jio_strb_t;

endpackage

// File: design/jio_settings.svh
/* Offsets are word-aligned byte addresses in the local 0x0000-0xFFFF space.
   Address bit 0 is ignored. The timer width must not exceed the data width. */
`ifndef JIO_SETTINGS_SVH
`define JIO_SETTINGS_SVH

// Bus widths
`define JIO_ADR_W 16
`define JIO_DAT_W 16

// Counter width of both timers
`define JIO_TMR_W 16

// Timer reload registers, write side
`define JIO_PIT1_ADR 16'h0000
`define JIO_PIT2_ADR 16'h0002
`define JIO_PIT3_ADR 16'h0004
`define JIO_PIT4_ADR 16'h0006

// Timer count readback, read side
`define JIO_PIT1R_ADR 16'h0036
`define JIO_PIT2R_ADR 16'h0038
`define JIO_PIT3R_ADR 16'h003A
`define JIO_PIT4R_ADR 16'h003C

// Interrupt enable and pending register
`define JIO_INT_ADR 16'h0020

// External device window, split into six selects
`define JIO_GPIO_LO 16'h4800
`define JIO_GPIO_HI 16'h7FFF

`endif
